//--- busCtrl/busSequencer.sv
module busSequencer (
	input logic clk,
	input logic rst,
	memAccessIf.receiver acc,
	output logic respValid,
	output logic [memBusPkg::dataWidth-1:0] respData,
	output logic [memBusPkg::addrWidth-1:0] ramAddr,
	inout wire [memBusPkg::dataWidth-1:0] ramData,
	output logic ramEn,
	output logic ramOe,
	output logic ramWe,
	output logic uartRdn,
	output logic uartWrn,
	input logic dataReady,
	input logic tbre,
	input logic tsre
);
	import memBusPkg::*;

	seqState state;
	seqState nextState;
	logic [stepWidth-1:0] stepCnt;
	logic stepDone;
	logic finish;
	logic [addrWidth-1:0] addrReg;
	logic [dataWidth-1:0] wrData;
	logic driveData;
	logic [dataWidth-1:0] statusWord;

	// Strobe levels for the state being entered
	logic nextEn;
	logic nextOe;
	logic nextWe;
	logic nextRdn;
	logic nextWrn;
	logic nextDrive;

	assign stepDone = (stepCnt == stepWidth'(busStepCycles - 1));
	assign finish = (state != idle) && (nextState == idle);
	assign ramAddr = addrReg;
	assign ramData = driveData ? wrData : 'z;

	always_comb begin
		statusWord = '0;
		statusWord[statusReadyBit] = dataReady;
		statusWord[statusTbreBit] = tbre;
	end

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			idle: begin
				if (acc.valid) begin
					case (acc.op)
						opRamRead: nextState = ramRead1;
						opRamWrite: nextState = ramWrite1;
						opUartRead: nextState = uartRead1;
						opUartWrite: nextState = uartWrite1;
						opStatusRead: nextState = statusRead;
						default: nextState = idle;
					endcase
				end
			end
			ramRead1: if (stepDone) nextState = ramRead2;
			ramRead2: if (stepDone) nextState = ramRead3;
			ramRead3: if (stepDone) nextState = idle;
			ramWrite1: if (stepDone) nextState = ramWrite2;
			ramWrite2: if (stepDone) nextState = ramWrite3;
			ramWrite3: if (stepDone) nextState = idle;
			// Wait for a received byte
			uartRead1: if (stepDone && dataReady) nextState = uartRead2;
			uartRead2: if (stepDone) nextState = uartRead3;
			uartRead3: if (stepDone) nextState = idle;
			uartWrite1: if (stepDone) nextState = uartWrite2;
			uartWrite2: if (stepDone) nextState = uartWrite3;
			// Holding register empty, then shift register empty
			uartWrite3: if (stepDone && tbre) nextState = uartWrite4;
			uartWrite4: if (stepDone && tsre) nextState = uartWrite5;
			uartWrite5: if (stepDone) nextState = idle;
			statusRead: nextState = idle;
			default: nextState = idle;
		endcase
	end

	////////////////////////////////////////
	// Strobe patterns per state
	////////////////////////////////////////

	always_comb begin
		nextEn = 1'b1;
		nextOe = 1'b1;
		nextWe = 1'b1;
		nextRdn = 1'b1;
		nextWrn = 1'b1;
		nextDrive = 1'b0;
		case (nextState)
			ramRead1, ramRead2, ramRead3: begin
				nextEn = 1'b0;
				nextOe = 1'b0;
			end
			ramWrite1, ramWrite3: begin
				nextEn = 1'b0;
				nextDrive = 1'b1;
			end
			ramWrite2: begin
				nextEn = 1'b0;
				nextWe = 1'b0;
				nextDrive = 1'b1;
			end
			uartRead2: nextRdn = 1'b0;
			// Byte held past the rising edge of wrn
			uartWrite1, uartWrite3: nextDrive = 1'b1;
			uartWrite2: begin
				nextWrn = 1'b0;
				nextDrive = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= idle;
			stepCnt <= '0;
			respValid <= 1'b0;
			acc.credit <= 1'b0;
			ramEn <= 1'b1;
			ramOe <= 1'b1;
			ramWe <= 1'b1;
			uartRdn <= 1'b1;
			uartWrn <= 1'b1;
			driveData <= 1'b0;
		end else begin
			state <= nextState;
			if ((state == idle) || (state == statusRead) || stepDone) begin
				stepCnt <= '0;
			end else begin
				stepCnt <= stepCnt + 1'b1;
			end
			respValid <= finish;
			acc.credit <= finish;
			ramEn <= nextEn;
			ramOe <= nextOe;
			ramWe <= nextWe;
			uartRdn <= nextRdn;
			uartWrn <= nextWrn;
			driveData <= nextDrive;
		end
	end

	always_ff @(posedge clk) begin
		if ((state == idle) && acc.valid) begin
			addrReg <= acc.addr;
			if (acc.op == opUartWrite) begin
				wrData <= dataWidth'(acc.data[uartByteWidth-1:0]);
			end else begin
				wrData <= acc.data;
			end
		end
		if ((state == ramRead3) && stepDone) begin
			respData <= ramData;
		end
		if ((state == uartRead2) && stepDone) begin
			respData <= dataWidth'(ramData[uartByteWidth-1:0]);
		end
		if (state == statusRead) begin
			respData <= statusWord;
		end
	end

	// SRAM and UART never own the bus together
	strobesExclusive: assert property (@(posedge clk) disable iff (!rst)
		!((!ramEn || !ramOe || !ramWe) && (!uartRdn || !uartWrn)));

	// No contention with SRAM output drivers
	busDriveSafe: assert property (@(posedge clk) disable iff (!rst)
		driveData |-> ramOe);

endmodule

//--- common/memAccessIf.sv
interface memAccessIf;
	import memBusPkg::*;

	// Access offered for one cycle by the sender
	logic valid;
	accessOp op;
	logic [addrWidth-1:0] addr;
	logic [dataWidth-1:0] data;

	// One pulse returns one credit to the sender
	logic credit;

	modport sender (
		output valid,
		output op,
		output addr,
		output data,
		input credit
	);

	modport receiver (
		input valid,
		input op,
		input addr,
		input data,
		output credit
	);

endinterface

//--- common/memBusPkg.sv
package memBusPkg;

	////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////

	localparam int addrWidth = 16;
	localparam int dataWidth = 16;
	localparam int uartByteWidth = 8;

	// Only these two addresses are not SRAM
	localparam logic [addrWidth-1:0] uartDataAddr = 16'hBF00;
	localparam logic [addrWidth-1:0] uartStatusAddr = 16'hBF01;

	// Status word layout
	localparam int statusReadyBit = 0;
	localparam int statusTbreBit = 1;

	////////////////////////////////////////
	// Queueing and credits
	////////////////////////////////////////

	localparam int reqQueueDepth = 4;
	localparam int queuePtrWidth = $clog2(reqQueueDepth);
	// Wide enough for a queue fill level or any credit count
	localparam int creditWidth = $clog2(reqQueueDepth + 1);
	// Each internal stage holds a single access
	localparam int stageCredits = 1;

	// Clock cycles per sequencer step
	localparam int busStepCycles = 2;
	localparam int stepWidth = $clog2(busStepCycles + 1);

	typedef enum logic [2:0] {
		opRamRead,
		opRamWrite,
		opUartRead,
		opUartWrite,
		opStatusRead
	} accessOp;

	typedef enum logic [4:0] {
		idle,
		ramRead1,
		ramRead2,
		ramRead3,
		ramWrite1,
		ramWrite2,
		ramWrite3,
		uartRead1,
		uartRead2,
		uartRead3,
		uartWrite1,
		uartWrite2,
		uartWrite3,
		uartWrite4,
		uartWrite5,
		statusRead
	} seqState;

endpackage

//--- hdl/accessDecoder.sv
module accessDecoder #(
	parameter int initCredits = 1
) (
	input logic clk,
	input logic rst,
	memAccessIf.receiver up,
	memAccessIf.sender down
);
	import memBusPkg::*;

	logic held;
	accessOp heldOp;
	accessOp nextOp;
	logic [addrWidth-1:0] heldAddr;
	logic [dataWidth-1:0] heldData;
	logic [creditWidth-1:0] credits;
	logic fwd;
	logic isWrite;

	assign isWrite = (up.op == opRamWrite);

	////////////////////////////////////////
	// Address classification
	////////////////////////////////////////

	always_comb begin
		if (up.addr == uartDataAddr) begin
			nextOp = isWrite ? opUartWrite : opUartRead;
		end else if ((up.addr == uartStatusAddr) && !isWrite) begin
			nextOp = opStatusRead;
		end else begin
			// Status writes fall through to SRAM
			nextOp = isWrite ? opRamWrite : opRamRead;
		end
	end

	assign fwd = held && (credits != '0);

	assign down.valid = fwd;
	assign down.op = heldOp;
	assign down.addr = heldAddr;
	assign down.data = heldData;

	always_ff @(posedge clk) begin
		if (up.valid) begin
			heldOp <= nextOp;
			heldAddr <= up.addr;
			heldData <= up.data;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			held <= 1'b0;
			credits <= creditWidth'(initCredits);
			up.credit <= 1'b0;
		end else begin
			if (up.valid) begin
				held <= 1'b1;
			end else if (fwd) begin
				held <= 1'b0;
			end
			credits <= credits + creditWidth'(down.credit) - creditWidth'(fwd);
			// Register free again once the access has left
			up.credit <= fwd;
		end
	end

	// Queue must wait for the credit before sending again
	noOverrun: assert property (@(posedge clk) disable iff (!rst)
		up.valid |-> !held);

endmodule

//--- hdl/memSubsystem.sv
module memSubsystem (
	input logic clk,
	input logic rst,
	input logic reqValid,
	input logic reqWrite,
	input logic [memBusPkg::addrWidth-1:0] reqAddr,
	input logic [memBusPkg::dataWidth-1:0] reqData,
	output logic reqCredit,
	output logic respValid,
	output logic [memBusPkg::dataWidth-1:0] respData,
	output logic [memBusPkg::addrWidth-1:0] ramAddr,
	inout wire [memBusPkg::dataWidth-1:0] ramData,
	output logic ramEn,
	output logic ramOe,
	output logic ramWe,
	output logic uartRdn,
	output logic uartWrn,
	input logic dataReady,
	input logic tbre,
	input logic tsre
);
	import memBusPkg::*;

	memAccessIf qToDec();
	memAccessIf decToSeq();

	reqQueue #(
		.initCredits(stageCredits)
	) queue (
		.clk(clk),
		.rst(rst),
		.reqValid(reqValid),
		.reqWrite(reqWrite),
		.reqAddr(reqAddr),
		.reqData(reqData),
		.reqCredit(reqCredit),
		.deq(qToDec.sender)
	);

	accessDecoder #(
		.initCredits(stageCredits)
	) decoder (
		.clk(clk),
		.rst(rst),
		.up(qToDec.receiver),
		.down(decToSeq.sender)
	);

	busSequencer sequencer (
		.clk(clk),
		.rst(rst),
		.acc(decToSeq.receiver),
		.respValid(respValid),
		.respData(respData),
		.ramAddr(ramAddr),
		.ramData(ramData),
		.ramEn(ramEn),
		.ramOe(ramOe),
		.ramWe(ramWe),
		.uartRdn(uartRdn),
		.uartWrn(uartWrn),
		.dataReady(dataReady),
		.tbre(tbre),
		.tsre(tsre)
	);

endmodule

//--- hdl/reqQueue.sv
module reqQueue #(
	parameter int initCredits = 1
) (
	input logic clk,
	input logic rst,
	input logic reqValid,
	input logic reqWrite,
	input logic [memBusPkg::addrWidth-1:0] reqAddr,
	input logic [memBusPkg::dataWidth-1:0] reqData,
	output logic reqCredit,
	memAccessIf.sender deq
);
	import memBusPkg::*;

	// Entry storage
	logic writeMem [reqQueueDepth];
	logic [addrWidth-1:0] addrMem [reqQueueDepth];
	logic [dataWidth-1:0] dataMem [reqQueueDepth];

	logic [queuePtrWidth-1:0] wrPtr;
	logic [queuePtrWidth-1:0] rdPtr;
	logic [creditWidth-1:0] count;
	logic [creditWidth-1:0] credits;
	logic pop;

	function automatic logic [queuePtrWidth-1:0] nextPtr(input logic [queuePtrWidth-1:0] ptr);
		logic atEnd;
		atEnd = (ptr == queuePtrWidth'(reqQueueDepth - 1));
		return atEnd ? '0 : ptr + 1'b1;
	endfunction

	assign pop = (count != '0) && (credits != '0);

	////////////////////////////////////////
	// Head of queue toward the decoder
	////////////////////////////////////////

	assign deq.valid = pop;
	// Decoder refines the direction by address
	assign deq.op = writeMem[rdPtr] ? opRamWrite : opRamRead;
	assign deq.addr = addrMem[rdPtr];
	assign deq.data = dataMem[rdPtr];

	always_ff @(posedge clk) begin
		if (reqValid) begin
			writeMem[wrPtr] <= reqWrite;
			addrMem[wrPtr] <= reqAddr;
			dataMem[wrPtr] <= reqData;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			credits <= creditWidth'(initCredits);
			reqCredit <= 1'b0;
		end else begin
			if (reqValid) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			count <= count + creditWidth'(reqValid) - creditWidth'(pop);
			credits <= credits + creditWidth'(deq.credit) - creditWidth'(pop);
			// Freed entry goes back to the CPU
			reqCredit <= pop;
		end
	end

	// CPU pushed without holding a credit
	noPushWhenFull: assert property (@(posedge clk) disable iff (!rst)
		reqValid |-> count != creditWidth'(reqQueueDepth));

	// Decoder returned more credits than it was given
	creditBound: assert property (@(posedge clk) disable iff (!rst)
		credits <= creditWidth'(initCredits));

endmodule

//--- tb.f
common/memBusPkg.sv
common/memAccessIf.sv
hdl/reqQueue.sv
hdl/accessDecoder.sv
busCtrl/busSequencer.sv
hdl/memSubsystem.sv
verification/tbBusModels.sv
verification/tbMemSubsystem.sv

//--- verification/tbBusModels.sv
module sramModel (
	input logic [memBusPkg::addrWidth-1:0] ramAddr,
	inout wire [memBusPkg::dataWidth-1:0] ramData,
	input logic ramEn,
	input logic ramOe,
	input logic ramWe
);
	import memBusPkg::*;

	logic [dataWidth-1:0] mem [2**addrWidth];

	initial begin
		for (int i = 0; i < 2**addrWidth; i++) begin
			// Odd multiplier keeps every word distinct
			mem[i] = dataWidth'(i * 40503) ^ 16'h3C5A;
		end
	end

	assign ramData = (!ramEn && !ramOe) ? mem[ramAddr] : 'z;

	// Word latched as the write strobe rises
	always @(posedge ramWe) begin
		if (!ramEn) begin
			mem[ramAddr] <= ramData;
		end
	end

endmodule

module uartChipModel (
	input logic clk,
	input logic rst,
	inout wire [memBusPkg::dataWidth-1:0] ramData,
	input logic uartRdn,
	input logic uartWrn,
	input logic rxLoad,
	input logic [memBusPkg::uartByteWidth-1:0] rxByte,
	input logic [7:0] txDelay,
	output logic dataReady,
	output logic tbre,
	output logic tsre
);
	import memBusPkg::*;

	logic [uartByteWidth-1:0] rxReg;
	logic [7:0] txCnt;

	assign ramData[uartByteWidth-1:0] = uartRdn ? 'z : rxReg;

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			rxReg <= '0;
			dataReady <= 1'b0;
			tbre <= 1'b1;
			tsre <= 1'b1;
			txCnt <= '0;
		end else begin
			// Byte arriving from the serial line
			if (rxLoad) begin
				rxReg <= rxByte;
				dataReady <= 1'b1;
			end else if (!uartRdn) begin
				dataReady <= 1'b0;
			end
			// Holding register busy, then shift register busy
			if (!uartWrn) begin
				tbre <= 1'b0;
				tsre <= 1'b0;
				txCnt <= txDelay;
			end else if (txCnt != '0) begin
				txCnt <= txCnt - 1'b1;
			end else if (!tbre) begin
				tbre <= 1'b1;
				txCnt <= txDelay;
			end else if (!tsre) begin
				tsre <= 1'b1;
			end
		end
	end

endmodule

//--- verification/tbMemSubsystem.sv
module tbMemSubsystem;
	import memBusPkg::*;

	typedef enum logic [1:0] {kWrite, kRead, kUartWrite, kUartRead} respKind;

	localparam int resetCycles = 10;
	localparam int ramPairs = 12;
	localparam int freshReads = 4;
	localparam int uartWrites = 4;
	localparam int uartReads = 3;
	localparam int burstLen = 8;
	// Two status reads and one read of a preloaded byte on top
	localparam int plannedReqs = 2 * ramPairs + freshReads + uartWrites + uartReads + burstLen + 3;
	localparam int watchdogCycles = resetCycles + 200 * plannedReqs;

	logic clk = 1'b0;
	logic rst;
	logic reqValid;
	logic reqWrite;
	logic [addrWidth-1:0] reqAddr;
	logic [dataWidth-1:0] reqData;
	logic reqCredit;
	logic respValid;
	logic [dataWidth-1:0] respData;
	logic [addrWidth-1:0] ramAddr;
	wire [dataWidth-1:0] ramData;
	logic ramEn;
	logic ramOe;
	logic ramWe;
	logic uartRdn;
	logic uartWrn;
	logic dataReady;
	logic tbre;
	logic tsre;
	logic rxLoad;
	logic [uartByteWidth-1:0] rxByte;
	logic [7:0] txDelay;

	// Scoreboard in issue order
	logic [dataWidth-1:0] refMem [2**addrWidth];
	respKind expKind [64];
	logic [dataWidth-1:0] expData [64];
	logic [addrWidth-1:0] addrList [ramPairs];
	respKind headKind;
	logic [dataWidth-1:0] headData;
	int issuedCnt = 0;
	int creditCnt = 0;
	int respCnt = 0;
	int rxLoads = 0;
	int uartReadsDone = 0;
	logic tsreSeen = 1'b1;

	memSubsystem DUT (.*);

	sramModel sram (.*);

	uartChipModel uart (.*);

	always #20 clk = ~clk;

	assign headKind = expKind[respCnt[5:0]];
	assign headData = expData[respCnt[5:0]];

	always @(posedge clk) begin
		if (reqCredit) begin
			creditCnt <= creditCnt + 1;
		end
		if (respValid) begin
			respCnt <= respCnt + 1;
			if (headKind == kUartRead) begin
				uartReadsDone <= uartReadsDone + 1;
			end
		end
		if (!uartWrn) begin
			tsreSeen <= 1'b0;
		end else if (tsre) begin
			tsreSeen <= 1'b1;
		end
	end

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	respCheck: assert property (@(posedge clk) disable iff (!rst)
		respValid && (headKind == kRead || headKind == kUartRead) |-> respData == headData)
		else stopRun($sformatf("** Error at %0t: response %0d is 0x%04h, expected 0x%04h",
			$time, $sampled(respCnt), $sampled(respData), $sampled(headData)));

	noExtraResp: assert property (@(posedge clk) disable iff (!rst)
		respValid |-> respCnt < issuedCnt)
		else stopRun("A response arrived with no request outstanding");

	txByteCheck: assert property (@(posedge clk) disable iff (!rst)
		$rose(uartWrn) |-> headKind == kUartWrite && ramData[7:0] == headData[7:0])
		else stopRun($sformatf("** Error at %0t: UART write byte 0x%02h, expected 0x%02h",
			$time, $sampled(ramData[7:0]), $sampled(headData[7:0])));

	txAfterTsre: assert property (@(posedge clk) disable iff (!rst)
		respValid && headKind == kUartWrite |-> tsreSeen)
		else stopRun("A UART write finished before tsre went high");

	rxAfterReady: assert property (@(posedge clk) disable iff (!rst)
		respValid && headKind == kUartRead |-> rxLoads > uartReadsDone)
		else stopRun("A UART read finished before dataReady was high");

	creditCheck: assert property (@(posedge clk) disable iff (!rst)
		creditCnt <= issuedCnt && issuedCnt - creditCnt <= reqQueueDepth)
		else stopRun("Credits returned or requests outstanding went out of range");

	resetValues: assert property (@(posedge clk)
		!rst |-> ramEn && ramOe && ramWe && uartRdn && uartWrn && !respValid && !reqCredit)
		else stopRun("Outputs were not idle during reset");

	strobesApart: assert property (@(posedge clk) disable iff (!rst)
		!((!ramEn || !ramOe || !ramWe) && (!uartRdn || !uartWrn)))
		else stopRun("SRAM and UART strobes were active together");

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		stopRun("Watchdog expired, the run hung waiting on the DUT");
	end

	////////////////////////////////////////
	// CPU side driver
	////////////////////////////////////////

	task automatic waitCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic issue(input logic wr, input logic [15:0] addr, input logic [15:0] data,
			input respKind kind, input logic [15:0] expWord);
		// Zero credits left
		while (issuedCnt - creditCnt >= reqQueueDepth) begin
			waitCycles(1);
		end
		expKind[issuedCnt[5:0]] = kind;
		expData[issuedCnt[5:0]] = expWord;
		reqValid = 1'b1;
		reqWrite = wr;
		reqAddr = addr;
		reqData = data;
		issuedCnt++;
		waitCycles(1);
		reqValid = 1'b0;
	endtask

	function automatic logic [15:0] randRamAddr();
		logic [15:0] a;
		a = $urandom;
		if (a == uartDataAddr || a == uartStatusAddr) begin
			a[15] = ~a[15];
		end
		return a;
	endfunction

	task automatic ramWrite(input logic [15:0] addr, input logic [15:0] data);
		refMem[addr] = data;
		issue(1'b1, addr, data, kWrite, data);
	endtask

	task automatic ramRead(input logic [15:0] addr);
		issue(1'b0, addr, 16'h0000, kRead, refMem[addr]);
	endtask

	task automatic uartWrite(input logic [15:0] data);
		issue(1'b1, uartDataAddr, data, kUartWrite, {8'h00, data[7:0]});
	endtask

	task automatic loadRx(input logic [7:0] b);
		rxByte = b;
		rxLoad = 1'b1;
		rxLoads++;
		waitCycles(1);
		rxLoad = 1'b0;
	endtask

	task automatic uartRead(input logic [7:0] b, input logic load);
		issue(1'b0, uartDataAddr, 16'h0000, kUartRead, {8'h00, b});
		if (load) begin
			// Byte arrives later than an unstalled read would finish
			waitCycles(10 + $urandom_range(10));
			loadRx(b);
		end
	endtask

	task automatic drain();
		while (respCnt != issuedCnt) begin
			waitCycles(1);
		end
	endtask

	task automatic statusRead();
		logic [15:0] expWord;
		drain();
		while (!(tbre && tsre)) begin
			waitCycles(1);
		end
		// Pins now stay put until the response
		expWord = '0;
		expWord[statusReadyBit] = dataReady;
		expWord[statusTbreBit] = tbre;
		issue(1'b0, uartStatusAddr, 16'h0000, kRead, expWord);
	endtask

	initial begin
		int unsigned discard;
		logic [7:0] heldByte;
		discard = $urandom(32'h8558_0fe8);
		rst = 1'b1;
		reqValid = 1'b0;
		reqWrite = 1'b0;
		reqAddr = '0;
		reqData = '0;
		rxLoad = 1'b0;
		rxByte = '0;
		txDelay = 8'd4;
		#1 rst = 1'b0;
		repeat (resetCycles) @(posedge clk);
		for (int i = 0; i < 2**addrWidth; i++) begin
			refMem[i] = sram.mem[i];
		end
		#2 rst = 1'b1;

		for (int i = 0; i < ramPairs; i++) begin
			addrList[i] = randRamAddr();
			ramWrite(addrList[i], $urandom);
			waitCycles($urandom_range(3));
		end
		for (int i = 0; i < ramPairs; i++) begin
			ramRead(addrList[i]);
			waitCycles($urandom_range(3));
		end
		for (int i = 0; i < freshReads; i++) begin
			ramRead(randRamAddr());
		end

		// Receiver empty
		statusRead();
		for (int i = 0; i < uartWrites; i++) begin
			txDelay = $urandom_range(8);
			uartWrite($urandom);
			waitCycles($urandom_range(3));
		end
		for (int i = 0; i < uartReads; i++) begin
			uartRead($urandom, 1'b1);
			drain();
		end

		// Byte waiting in the receiver
		drain();
		heldByte = $urandom;
		loadRx(heldByte);
		statusRead();
		uartRead(heldByte, 1'b0);

		// Slow UART backs up the queue
		drain();
		txDelay = 8'd40;
		for (int i = 0; i < burstLen; i++) begin
			case (i % 3)
				0: uartWrite($urandom);
				1: ramWrite(randRamAddr(), $urandom);
				default: ramRead(addrList[i]);
			endcase
		end
		drain();

		if (creditCnt != issuedCnt) begin
			stopRun("Not every queue entry was freed by the end of the run");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule
